// ==== sources.f ====
+incdir+.
ohci_ed_pkg.sv
ohci_ed_regs.sv
ohci_ed_fetch.sv
ohci_ed_queue.sv
ohci_ed_top.sv
tb_ohci_ed_mem.sv
tb_ohci_ed.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_ohci_ed -Mdir obj_dir -o tb_ohci_ed -f sources.f

run: compile
	./obj_dir/tb_ohci_ed | tee sim.log
	grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_ohci_ed.sv ====
// OHCI ED fetch path testbench walking descriptor lists and checking each first-in pop
`default_nettype none
`include "ohci_ed_defines.svh"

module tb_ohci_ed;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_tests = 6;

    logic                            clk;
    logic                            rst_n;
    logic                            cfg_valid;
    ohci_ed_pkg::cfg_req_t           cfg_req;
    logic [31:0]                     cfg_rdata;
    logic                            rd_req_valid;
    ohci_ed_pkg::rd_req_t            rd_req;
    logic                            rd_rsp_valid;
    ohci_ed_pkg::rd_rsp_t            rd_rsp;
    logic                            pop;
    logic                            pop_ready;
    logic                            np2p;
    logic                            p2np;
    logic                            firstin_valid;
    ohci_ed_pkg::endpoint_descriptor firstin;
    logic                            slow_mem;
    logic                            cfg_seen;
    int                              outstanding; // reads in flight
    int                              errors;
    int                              failed_tests;
    int                              test_start_errors;
    ohci_ed_pkg::endpoint_descriptor model_ed [logic [31:0]]; // keyed by byte address
    ohci_ed_pkg::endpoint_descriptor np_q [$];                // nonempty EDs in list order
    ohci_ed_pkg::endpoint_descriptor p_q [$];
    ohci_ed_pkg::endpoint_descriptor stash_exp;

    ohci_ed_top dut_i (
        .clk_i                 (clk),
        .rst_n_i               (rst_n),
        .cfg_valid_i           (cfg_valid),
        .cfg_req_i             (cfg_req),
        .cfg_rdata_o           (cfg_rdata),
        .rd_req_valid_o        (rd_req_valid),
        .rd_req_o              (rd_req),
        .rd_rsp_valid_i        (rd_rsp_valid),
        .rd_rsp_i              (rd_rsp),
        .pop_i                 (pop),
        .pop_ready_o           (pop_ready),
        .context_switch_np2p_i (np2p),
        .context_switch_p2np_i (p2np),
        .firstin_valid_o       (firstin_valid),
        .firstin_o             (firstin)
    );

    tb_ohci_ed_mem mem_i (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .slow_i      (slow_mem),
        .req_valid_i (rd_req_valid),
        .req_i       (rd_req),
        .rsp_valid_o (rd_rsp_valid),
        .rsp_o       (rd_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) outstanding <= 0;
        else outstanding <= outstanding + int'(rd_req_valid) - int'(rd_rsp_valid);
    end

    // quiet until software sets up a list
    assert property (@(posedge clk) disable iff (!rst_n)
                     !cfg_seen |-> !(pop_ready || firstin_valid || rd_req_valid))
        else begin
            $display("Error at %0t: DUT active before the first config write", $time);
            errors++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) outstanding <= `OHCI_ED_RD_CREDITS)
        else begin
            $display("Error at %0t: %0d reads outstanding, above the credit pool", $time,
                     outstanding);
            errors++;
        end

    // loaded second-in holds the fetch off
    assert property (@(posedge clk) disable iff (!rst_n) pop_ready |-> !rd_req_valid)
        else begin
            $display("Error at %0t: read request issued with a descriptor waiting", $time);
            errors++;
        end

    function automatic ohci_ed_pkg::endpoint_descriptor make_ed(
        input logic [26:0] st, input logic [31:0] tail, input logic [31:0] head,
        input logic c, input logic h, input logic [31:0] next);
        ohci_ed_pkg::endpoint_descriptor ed;
        ed.status          = st;
        ed.tail_td         = tail[31:4];
        ed.head_td.address = head[31:4];
        ed.head_td.c       = c;
        ed.head_td.h       = h;
        ed.next_ed.address = next[31:4];
        return ed;
    endfunction

    // OHCI dword layout in memory with a model copy kept beside it
    task automatic place_ed(input logic [31:0] addr, input ohci_ed_pkg::endpoint_descriptor ed);
        mem_i.write_word(addr, {5'h0, ed.status});
        mem_i.write_word(addr + 32'd4, {ed.tail_td, 4'h0});
        mem_i.write_word(addr + 32'd8, {ed.head_td.address, 2'b00, ed.head_td.c, ed.head_td.h});
        mem_i.write_word(addr + 32'd12, {ed.next_ed.address, 4'h0});
        model_ed[addr] = ed;
    endtask

    // follow next-ED from the head and keep only nonempty EDs
    task automatic walk_list(input logic [31:0] head, input bit periodic);
        logic [31:0]                     a;
        ohci_ed_pkg::endpoint_descriptor ed;
        a = head;
        while (a != 32'h0 && model_ed.exists(a)) begin
            ed = model_ed[a];
            if (ed.tail_td != ed.head_td.address) begin
                if (periodic) p_q.push_back(ed);
                else np_q.push_back(ed);
            end
            a = {ed.next_ed.address, 4'h0};
        end
    endtask

    task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
        cfg_seen     = 1'b1;
        cfg_valid    = 1'b1;
        cfg_req.op   = ohci_ed_pkg::CFG_WRITE;
        cfg_req.addr = addr;
        cfg_req.data = data;
        @(posedge clk);
        #2;
        cfg_valid = 1'b0;
    endtask

    // read data is registered at the edge that takes the access
    task automatic readback_check(input logic [1:0] addr, input logic [31:0] exp);
        cfg_valid    = 1'b1;
        cfg_req.op   = ohci_ed_pkg::CFG_READ;
        cfg_req.addr = addr;
        cfg_req.data = '0;
        @(posedge clk);
        #2;
        cfg_valid = 1'b0;
        assert (cfg_rdata == exp) else begin
            $display("Error at %0t: cfg_rdata_o got %h expected %h", $time, cfg_rdata, exp);
            errors++;
        end
    endtask

    task automatic wait_ready(output bit ok);
        int cycles;
        cycles = 0;
        while (!pop_ready && cycles < 300) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        ok = pop_ready;
        if (!ok) begin
            $display("Error at %0t: no descriptor ready to pop after %0d cycles", $time, cycles);
            errors++;
        end
    endtask

    task automatic pop_check(input ohci_ed_pkg::endpoint_descriptor exp);
        bit ok;
        wait_ready(ok);
        if (ok) begin
            pop = 1'b1;
            @(posedge clk);
            #2;
            pop = 1'b0; // first-in settled while the next fetch is still far off
            assert (firstin_valid) else begin
                $display("Error at %0t: firstin_valid_o got 0 expected 1", $time);
                errors++;
            end
            assert (firstin == exp) else begin
                $display("Error at %0t: firstin_o got %h expected %h", $time, firstin, exp);
                errors++;
            end
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_start_errors) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail, %0d errors", name, errors - test_start_errors);
            failed_tests++;
        end
        test_start_errors = errors;
    endtask

    initial begin
        bit ok;
        int hold_reqs;
        rst_n             = 1'b0;
        cfg_valid         = 1'b0;
        cfg_req           = '0;
        pop               = 1'b0;
        np2p              = 1'b0;
        p2np              = 1'b0;
        slow_mem          = 1'b0;
        cfg_seen          = 1'b0;
        errors            = 0;
        failed_tests      = 0;
        test_start_errors = 0;
        hold_reqs         = 0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        repeat (20) @(posedge clk);
        #2;
        assert (!pop_ready && !firstin_valid && !rd_req_valid) else begin
            $display("Error at %0t: outputs active after reset with no list set up", $time);
            errors++;
        end
        end_test("reset_idle");

        // np list A B C D E with B empty and periodic list P1 P2
        place_ed(32'h100, make_ed(27'h0400081, 32'h1000, 32'h1010, 1'b1, 1'b0, 32'h140));
        place_ed(32'h140, make_ed(27'h0600012, 32'h1100, 32'h1100, 1'b0, 1'b0, 32'h180));
        place_ed(32'h180, make_ed(27'h0200102, 32'h1200, 32'h1230, 1'b0, 1'b0, 32'h1c0));
        place_ed(32'h1c0, make_ed(27'h1000183, 32'h1300, 32'h1340, 1'b1, 1'b1, 32'h200));
        place_ed(32'h200, make_ed(27'h0080204, 32'h1400, 32'h1450, 1'b0, 1'b1, 32'h0));
        place_ed(32'h300, make_ed(27'h0100285, 32'h2000, 32'h2010, 1'b1, 1'b0, 32'h340));
        place_ed(32'h340, make_ed(27'h0040306, 32'h2100, 32'h2120, 1'b0, 1'b0, 32'h0));
        walk_list(32'h100, 1'b0);
        walk_list(32'h300, 1'b1);

        slow_mem = 1'b1; // every read at the longest latency
        cfg_write(`OHCI_ED_ADDR_NPHEAD, 32'h100);
        cfg_write(`OHCI_ED_ADDR_PHEAD, 32'h300);
        cfg_write(`OHCI_ED_ADDR_CTRL, 32'h3);
        pop_check(np_q.pop_front());
        slow_mem = 1'b0;
        end_test("credit_limit");

        readback_check(`OHCI_ED_ADDR_NPHEAD, 32'h100);
        readback_check(`OHCI_ED_ADDR_PHEAD, 32'h300);
        readback_check(`OHCI_ED_ADDR_CTRL, 32'h3);
        end_test("cfg_readback");

        pop_check(np_q.pop_front()); // B skipped so C comes next
        end_test("empty_skip");

        wait_ready(ok);
        repeat (30) begin
            @(posedge clk);
            #2;
            if (rd_req_valid) hold_reqs++;
        end
        assert (hold_reqs == 0) else begin
            $display("Error at %0t: rd_req_valid_o got %0d requests expected 0", $time,
                     hold_reqs);
            errors++;
        end
        end_test("backpressure");

        stash_exp = np_q.pop_front(); // D parked by the switch
        np2p = 1'b1;
        @(posedge clk);
        #2;
        np2p = 1'b0;
        pop_check(p_q.pop_front());
        pop_check(p_q.pop_front());
        repeat (8) @(posedge clk); // periodic walk stops on null next-ED
        #2;
        p2np = 1'b1;
        @(posedge clk);
        #2;
        p2np = 1'b0;
        pop_check(stash_exp);
        pop_check(np_q.pop_front()); // walk resumes after the stashed ED
        end_test("context_switch");

        $display("tests %0d, failed %0d, errors %0d", num_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // 400 cycles a test plus reset
    initial begin
        repeat (16 + num_tests * 400) @(posedge clk);
        $display("Error: watchdog expired before the test sequence finished");
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_ohci_ed_mem.sv ====
// OHCI ED testbench memory giving in order read responses after a 1 to 6 cycle latency
`default_nettype none

module tb_ohci_ed_mem (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 slow_i,      // pin latency at the maximum
    input  logic                 req_valid_i,
    input  ohci_ed_pkg::rd_req_t req_i,
    output logic                 rsp_valid_o,
    output ohci_ed_pkg::rd_rsp_t rsp_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] mem [256]; // 1 KB word addressed

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        mem[addr[9:2]] = data;
    endtask

    initial begin
        int         cycle;
        int         due;
        int         last_due;
        logic [7:0] addr_q [$]; // word index per outstanding read
        int         due_q [$];
        void'($urandom(32'hce7e));
        for (int i = 0; i < 256; i++) begin
            mem[i] = {16'hf111, 8'(i), ~8'(i)}; // fill tied to the address
        end
        cycle       = 0;
        last_due    = 0;
        rsp_valid_o = 1'b0;
        rsp_o       = '0;
        forever begin
            @(posedge clk_i);
            #2;
            cycle++;
            if (!rst_n_i) begin
                addr_q.delete();
                due_q.delete();
                rsp_valid_o = 1'b0;
            end else begin
                // request shown now is taken at the next edge
                if (req_valid_i) begin
                    due = cycle + (slow_i ? 6 : int'($urandom_range(6, 1)));
                    if (due <= last_due) due = last_due + 1; // responses stay in order
                    last_due = due;
                    addr_q.push_back(req_i.addr[9:2]);
                    due_q.push_back(due);
                end
                rsp_valid_o = (due_q.size() != 0) && (due_q[0] <= cycle);
                if (rsp_valid_o) begin
                    rsp_o.data = mem[addr_q.pop_front()];
                    void'(due_q.pop_front());
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== ohci_ed_top.sv ====
// OHCI ED fetch path top joining the config block, list fetch engine and descriptor queue
`default_nettype none

module ohci_ed_top (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            cfg_valid_i,
    input  ohci_ed_pkg::cfg_req_t           cfg_req_i,
    output logic [31:0]                     cfg_rdata_o,
    output logic                            rd_req_valid_o,
    output ohci_ed_pkg::rd_req_t            rd_req_o,
    input  logic                            rd_rsp_valid_i,
    input  ohci_ed_pkg::rd_rsp_t            rd_rsp_i,
    input  logic                            pop_i,
    output logic                            pop_ready_o,
    input  logic                            context_switch_np2p_i,
    input  logic                            context_switch_p2np_i,
    output logic                            firstin_valid_o,
    output ohci_ed_pkg::endpoint_descriptor firstin_o
);
    ohci_ed_pkg::ed_pointer_t periodic_head;
    ohci_ed_pkg::ed_pointer_t nonperiodic_head;
    ohci_ed_pkg::ed_pointer_t next_ed;
    logic                     periodic_en;
    logic                     nonperiodic_en;
    logic                     secondin_loaded;
    logic                     advance; // queue moved past an ED

    ohci_ed_regs u_regs (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .cfg_valid_i        (cfg_valid_i),
        .cfg_req_i          (cfg_req_i),
        .cfg_rdata_o        (cfg_rdata_o),
        .periodic_head_o    (periodic_head),
        .nonperiodic_head_o (nonperiodic_head),
        .periodic_en_o      (periodic_en),
        .nonperiodic_en_o   (nonperiodic_en)
    );

    ohci_ed_fetch u_fetch (
        .clk_i                 (clk_i),
        .rst_n_i               (rst_n_i),
        .periodic_head_i       (periodic_head),
        .nonperiodic_head_i    (nonperiodic_head),
        .periodic_en_i         (periodic_en),
        .nonperiodic_en_i      (nonperiodic_en),
        .context_switch_np2p_i (context_switch_np2p_i),
        .context_switch_p2np_i (context_switch_p2np_i),
        .secondin_loaded_i     (secondin_loaded),
        .next_ed_i             (next_ed),
        .advance_i             (advance),
        .rd_req_valid_o        (rd_req_valid_o),
        .rd_req_o              (rd_req_o),
        .rd_rsp_valid_i        (rd_rsp_valid_i)
    );

    // response data feeds the queue directly
    ohci_ed_queue u_queue (
        .clk_i                 (clk_i),
        .rst_n_i               (rst_n_i),
        .pop_i                 (pop_i),
        .pop_ready_o           (pop_ready_o),
        .context_switch_np2p_i (context_switch_np2p_i),
        .context_switch_p2np_i (context_switch_p2np_i),
        .rsp_valid_i           (rd_rsp_valid_i),
        .rsp_i                 (rd_rsp_i),
        .secondin_loaded_o     (secondin_loaded),
        .advance_o             (advance),
        .next_ed_o             (next_ed),
        .firstin_valid_o       (firstin_valid_o),
        .firstin_o             (firstin_o)
    );

endmodule

`default_nettype wire

// ==== ohci_ed_queue.sv ====
// OHCI ED output queue with the second-in dword chain, first-in register and np stash
`default_nettype none
`include "ohci_ed_defines.svh"

module ohci_ed_queue (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            pop_i,
    output logic                            pop_ready_o,
    input  logic                            context_switch_np2p_i,
    input  logic                            context_switch_p2np_i,
    input  logic                            rsp_valid_i,
    input  ohci_ed_pkg::rd_rsp_t            rsp_i,
    output logic                            secondin_loaded_o,
    output logic                            advance_o,
    output ohci_ed_pkg::ed_pointer_t        next_ed_o,
    output logic                            firstin_valid_o,
    output ohci_ed_pkg::endpoint_descriptor firstin_o
);
    logic [`OHCI_ED_DW-1:0]          chain_q [`OHCI_ED_DWORDS]; // [0] newest dword
    logic [`OHCI_ED_DWORDS-1:0]      fill_q;                    // ones walk in beside data
    logic [`OHCI_ED_DW-1:0]          dw0;
    logic [`OHCI_ED_DW-1:0]          dw1;
    logic [`OHCI_ED_DW-1:0]          dw2;
    logic [`OHCI_ED_DW-1:0]          dw3;
    ohci_ed_pkg::endpoint_descriptor secondin;
    ohci_ed_pkg::endpoint_descriptor stash_q;
    ohci_ed_pkg::endpoint_descriptor secondin_mux;
    logic                            loaded;
    logic                            no_td;
    logic                            empty;
    logic                            valid;
    logic                            shift;
    logic                            clear;
    logic                            pop_fire;
    logic                            stash_load;
    logic                            stash_active_q; // np ED parked across periodic
    logic                            restore_q;      // stash is the next pop

    // dword0 is the oldest entry
    assign dw0 = chain_q[`OHCI_ED_DWORDS-1];
    assign dw1 = chain_q[`OHCI_ED_DWORDS-2];
    assign dw2 = chain_q[`OHCI_ED_DWORDS-3];
    assign dw3 = chain_q[`OHCI_ED_DWORDS-4];

    assign secondin.status = '{mps: dw0[26:16], f: dw0[15], k: dw0[14], s: dw0[13],
                               d: dw0[12:11], en: dw0[10:7], fa: dw0[6:0]};
    assign secondin.tail_td = dw1[31:4]; // compared with head TD for the empty check
    assign secondin.head_td = '{address: dw2[31:4], c: dw2[1], h: dw2[0]};
    assign secondin.next_ed = '{address: dw3[31:4]};

    assign loaded = fill_q[`OHCI_ED_DWORDS-1];
    assign no_td  = (secondin.tail_td == secondin.head_td.address);
    assign empty  = loaded && no_td;  // skipped by following next ED
    assign valid  = loaded && !no_td;

    assign shift      = rsp_valid_i && !loaded;
    assign stash_load = valid && context_switch_np2p_i;
    assign pop_ready_o = valid || restore_q;
    assign pop_fire    = pop_i && pop_ready_o;
    // switch mid burst lets the burst finish
    assign clear = loaded && ((pop_fire && !restore_q) || no_td ||
                              context_switch_np2p_i || context_switch_p2np_i);

    assign secondin_loaded_o = loaded || restore_q; // holds fetch off until stash pops
    assign secondin_mux      = restore_q ? stash_q : secondin;
    assign advance_o         = pop_fire || empty;
    assign next_ed_o         = secondin_mux.next_ed;

    always_ff @(posedge clk_i) begin
        if (shift) begin
            chain_q[0] <= rsp_i.data;
            for (int i = 1; i < `OHCI_ED_DWORDS; i++) begin
                chain_q[i] <= chain_q[i-1];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fill_q <= '0;
        end else if (clear) begin
            fill_q <= '0;  // data left stale
        end else if (shift) begin
            fill_q <= {fill_q[`OHCI_ED_DWORDS-2:0], 1'b1};
        end
    end

    // np2p parks a valid np ED and p2np arms it for the next pop
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stash_active_q <= 1'b0;
            restore_q      <= 1'b0;
        end else begin
            if (stash_load) stash_active_q <= 1'b1;
            else if (context_switch_p2np_i) stash_active_q <= 1'b0;
            if (context_switch_p2np_i && stash_active_q) restore_q <= 1'b1;
            else if (pop_fire) restore_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stash_load) stash_q <= secondin;
    end

    // stays valid after the first pop
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            firstin_valid_o <= 1'b0;
        end else if (pop_fire) begin
            firstin_valid_o <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_fire) begin
            firstin_o.status  <= secondin_mux.status;
            firstin_o.tail_td <= secondin_mux.tail_td;
            firstin_o.head_td <= secondin_mux.head_td;
        end
        if (advance_o) firstin_o.next_ed <= secondin_mux.next_ed; // also on empty ED
    end

endmodule

`default_nettype wire

// ==== ohci_ed_fetch.sv ====
// OHCI ED fetch engine walking the active ED list with credit gated dword reads
`default_nettype none
`include "ohci_ed_defines.svh"

module ohci_ed_fetch (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  ohci_ed_pkg::ed_pointer_t periodic_head_i,
    input  ohci_ed_pkg::ed_pointer_t nonperiodic_head_i,
    input  logic                     periodic_en_i,
    input  logic                     nonperiodic_en_i,
    input  logic                     context_switch_np2p_i,
    input  logic                     context_switch_p2np_i,
    input  logic                     secondin_loaded_i,
    input  ohci_ed_pkg::ed_pointer_t next_ed_i,
    input  logic                     advance_i, // pop or empty ED in the queue
    output logic                     rd_req_valid_o,
    output ohci_ed_pkg::rd_req_t     rd_req_o,
    input  logic                     rd_rsp_valid_i
);
    localparam int unsigned CreditW   = $clog2(`OHCI_ED_RD_CREDITS + 1);
    localparam logic [1:0]  LastDword = 2'(`OHCI_ED_DWORDS - 1);

    ohci_ed_pkg::fetch_state_e state_q;
    ohci_ed_pkg::list_kind_e   kind_q;
    ohci_ed_pkg::ed_pointer_t  cur_ed_q;   // next ED when not starting at the head
    ohci_ed_pkg::ed_pointer_t  burst_ed_q; // ED being read
    ohci_ed_pkg::ed_pointer_t  start_ed;
    logic                      from_head_q;
    logic                      list_en;
    logic                      start;
    logic [CreditW-1:0]        credits_q;
    logic [1:0]                req_idx_q; // requests sent in this burst
    logic [1:0]                rsp_idx_q; // responses seen in this burst

    assign list_en  = (kind_q == ohci_ed_pkg::PERIODIC) ? periodic_en_i : nonperiodic_en_i;
    assign start_ed = !from_head_q ? cur_ed_q :
                      (kind_q == ohci_ed_pkg::PERIODIC) ? periodic_head_i : nonperiodic_head_i;
    // null pointer parks the walk until a context switch
    assign start = (state_q == ohci_ed_pkg::IDLE) && !secondin_loaded_i && list_en &&
                   (start_ed.address != '0);

    assign rd_req_valid_o = (state_q == ohci_ed_pkg::ISSUE) && (credits_q != '0);
    assign rd_req_o.addr  = {burst_ed_q.address, req_idx_q, 2'b00};
    assign rd_req_o.idx   = req_idx_q;

    // one credit spent per request and returned per response
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credits_q <= CreditW'(`OHCI_ED_RD_CREDITS);
        end else begin
            credits_q <= credits_q - CreditW'(rd_req_valid_o) + CreditW'(rd_rsp_valid_i);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= ohci_ed_pkg::IDLE;
            req_idx_q <= '0;
            rsp_idx_q <= '0;
        end else begin
            if (rd_req_valid_o) req_idx_q <= req_idx_q + 2'd1; // wraps per burst
            if (rd_rsp_valid_i) rsp_idx_q <= rsp_idx_q + 2'd1;
            case (state_q)
                ohci_ed_pkg::IDLE:
                    if (start) state_q <= ohci_ed_pkg::ISSUE;
                ohci_ed_pkg::ISSUE:
                    if (rd_req_valid_o && req_idx_q == LastDword) state_q <= ohci_ed_pkg::WAIT_LOAD;
                ohci_ed_pkg::WAIT_LOAD: // last dword lands in the queue
                    if (rd_rsp_valid_i && rsp_idx_q == LastDword) state_q <= ohci_ed_pkg::IDLE;
                default: state_q <= ohci_ed_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) burst_ed_q <= start_ed;
    end

    // list kind and walk position where a switch wins over a same cycle advance
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            kind_q      <= ohci_ed_pkg::NONPERIODIC;
            from_head_q <= 1'b1;
            cur_ed_q    <= '0;
        end else begin
            if (advance_i) begin
                cur_ed_q    <= next_ed_i;
                from_head_q <= 1'b0;
            end
            if (context_switch_np2p_i) begin
                kind_q      <= ohci_ed_pkg::PERIODIC;
                from_head_q <= 1'b1;
            end else if (context_switch_p2np_i) begin
                kind_q      <= ohci_ed_pkg::NONPERIODIC;
                from_head_q <= 1'b1; // stash pop moves it on
            end
        end
    end

endmodule

`default_nettype wire

// ==== ohci_ed_regs.sv ====
// OHCI ED config block holding list head pointers and list enables for the fetch engine
`default_nettype none
`include "ohci_ed_defines.svh"

module ohci_ed_regs (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     cfg_valid_i,
    input  ohci_ed_pkg::cfg_req_t    cfg_req_i,
    output logic [`OHCI_ED_DW-1:0]   cfg_rdata_o,
    output ohci_ed_pkg::ed_pointer_t periodic_head_o,
    output ohci_ed_pkg::ed_pointer_t nonperiodic_head_o,
    output logic                     periodic_en_o,
    output logic                     nonperiodic_en_o
);
    ohci_ed_pkg::ed_pointer_t phead_q;
    ohci_ed_pkg::ed_pointer_t nphead_q;
    logic [1:0]               en_q;  // {nonperiodic, periodic}
    logic                     wr;
    logic                     rd;

    assign wr = cfg_valid_i && (cfg_req_i.op == ohci_ed_pkg::CFG_WRITE);
    assign rd = cfg_valid_i && (cfg_req_i.op == ohci_ed_pkg::CFG_READ);

    // write decode drops the low nibble of head writes
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phead_q  <= '0;
            nphead_q <= '0;
            en_q     <= 2'b00; // both lists off
        end else if (wr) begin
            case (cfg_req_i.addr)
                `OHCI_ED_ADDR_PHEAD:  phead_q.address  <= cfg_req_i.data[31:4];
                `OHCI_ED_ADDR_NPHEAD: nphead_q.address <= cfg_req_i.data[31:4];
                `OHCI_ED_ADDR_CTRL:   en_q             <= cfg_req_i.data[1:0];
                default: ;
            endcase
        end
    end

    // read data one cycle after the access
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_rdata_o <= '0;
        end else if (rd) begin
            case (cfg_req_i.addr)
                `OHCI_ED_ADDR_PHEAD:  cfg_rdata_o <= {phead_q.address, 4'h0};
                `OHCI_ED_ADDR_NPHEAD: cfg_rdata_o <= {nphead_q.address, 4'h0};
                `OHCI_ED_ADDR_CTRL:   cfg_rdata_o <= {30'h0, en_q};
                default:              cfg_rdata_o <= '0;
            endcase
        end
    end

    assign periodic_head_o    = phead_q;
    assign nonperiodic_head_o = nphead_q;
    assign periodic_en_o      = en_q[0];
    assign nonperiodic_en_o   = en_q[1];

endmodule

`default_nettype wire

// ==== ohci_ed_pkg.sv ====
// OHCI ED fetch path types for the descriptor layout, read port and config structs
`default_nettype none

package ohci_ed_pkg;

    // status dword in bits 26:0 of dword0
    typedef struct packed {
        logic [10:0] mps; // max packet size
        logic        f;   // format for iso TDs
        logic        k;   // skip
        logic        s;   // low speed
        logic [1:0]  d;   // direction
        logic [3:0]  en;  // endpoint number
        logic [6:0]  fa;  // function address
    } ed_status_t;

    typedef struct packed {
        logic [27:0] address; // 16 byte aligned TD
        logic        c;       // toggle carry
        logic        h;       // halted
    } td_pointer_t;

    typedef struct packed {
        logic [27:0] address; // 16 byte aligned ED where zero ends the list
    } ed_pointer_t;

    // the four dwords of an ED without reserved bits
    typedef struct packed {
        ed_status_t  status;
        logic [27:0] tail_td;
        td_pointer_t head_td;
        ed_pointer_t next_ed;
    } endpoint_descriptor;

    typedef struct packed {
        logic [31:0] addr; // byte address
        logic [1:0]  idx;  // dword within the ED
    } rd_req_t;

    typedef struct packed {
        logic [31:0] data;
    } rd_rsp_t;

    typedef enum logic {PERIODIC, NONPERIODIC} list_kind_e;
    typedef enum logic [1:0] {IDLE, ISSUE, WAIT_LOAD} fetch_state_e;
    typedef enum logic {CFG_WRITE, CFG_READ} cfg_op_e;

    typedef struct packed {
        cfg_op_e     op;
        logic [1:0]  addr;
        logic [31:0] data;
    } cfg_req_t;

endpackage

`default_nettype wire

// ==== ohci_ed_defines.svh ====
// OHCI ED fetch path widths, burst and credit counts, config register map
`ifndef OHCI_ED_DEFINES_SVH
`define OHCI_ED_DEFINES_SVH

// dword width in bits
`define OHCI_ED_DW 32
// dwords per endpoint descriptor, one read each
`define OHCI_ED_DWORDS 4
// outstanding reads the memory side must absorb
`define OHCI_ED_RD_CREDITS 4

// config register addresses
`define OHCI_ED_ADDR_PHEAD 2'd0
`define OHCI_ED_ADDR_NPHEAD 2'd1
// bit0 periodic enable, bit1 nonperiodic enable
`define OHCI_ED_ADDR_CTRL 2'd2

`endif
